//--- argmin_top.f
argmin_pkg.sv
argmin_node.sv
argmin_load.sv
argmin_level.sv
argmin_drain.sv
argmin_top.sv
argmin_checker.sv
argmin_tb.sv

//--- argmin_tb.sv
`timescale 1ns/10ps

module argmin_tb;

  typedef argmin_pkg::value_t [argmin_pkg::NUM_LANES-1:0] lanes_t;
  typedef logic [argmin_pkg::NUM_LANES-1:0]               mask_t;

  localparam int CLK_PERIOD       = 100;
  localparam int RESET_CYCLES     = 16;
  localparam int IDLE_CYCLES      = 20;
  localparam int SINGLE_VECTORS   = 12;
  localparam int SINGLE_GAP       = argmin_pkg::LATENCY + 2;
  localparam int BURST_CYCLES     = 64;
  localparam int TIE_CYCLES       = 48;
  localparam int MASK_CYCLES      = 64;
  localparam int DIRECTED_VECTORS = 6;
  localparam int DRAIN_CYCLES     = argmin_pkg::LATENCY + 4;
  localparam int MARGIN_CYCLES    = 50;

  // Sum of all phases, used by the watchdog
  localparam int TOTAL_CYCLES = RESET_CYCLES + IDLE_CYCLES
                              + SINGLE_VECTORS * (SINGLE_GAP + 1)
                              + BURST_CYCLES + TIE_CYCLES + MASK_CYCLES
                              + DIRECTED_VECTORS + DRAIN_CYCLES;

  localparam logic [15:0] LFSR_SEED = 16'd28;
  localparam logic [15:0] LFSR_TAPS = 16'hB400;

  logic               clk;
  logic               rst_n;
  logic               in_valid;
  lanes_t             in_values;
  mask_t              in_mask;
  logic               out_valid;
  argmin_pkg::index_t out_index;
  argmin_pkg::value_t out_value;
  logic               out_empty;

  logic [15:0] lfsr_state;

  argmin_top argmin_top_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_values (in_values),
    .in_mask   (in_mask),
    .out_valid (out_valid),
    .out_index (out_index),
    .out_value (out_value),
    .out_empty (out_empty)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  // Galois form, taps fold back in when a one shifts out
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    if (state[0]) begin
      return (state >> 1) ^ LFSR_TAPS;
    end else begin
      return state >> 1;
    end
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int width, output logic [15:0] bits);
    bits = '0;
    for (int i = 0; i < width; i++) begin
      bits[i]    = lfsr_state[0];
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  task automatic random_values(input int width, output lanes_t values);
    logic [15:0] bits;
    for (int lane = 0; lane < argmin_pkg::NUM_LANES; lane++) begin
      draw_bits(width, bits);
      values[lane] = bits;
    end
  endtask

  task automatic random_mask(output mask_t mask);
    logic [15:0] bits;
    draw_bits(argmin_pkg::NUM_LANES, bits);
    mask = bits[argmin_pkg::NUM_LANES-1:0];
  endtask

  function automatic lanes_t equal_lanes(input argmin_pkg::value_t value);
    lanes_t v;
    for (int lane = 0; lane < argmin_pkg::NUM_LANES; lane++) begin
      v[lane] = value;
    end
    return v;
  endfunction

  task automatic send_vector(input lanes_t values, input mask_t mask);
    @(posedge clk);
    in_valid  <= 1'b1;
    in_values <= values;
    in_mask   <= mask;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      in_valid <= 1'b0;
    end
  endtask

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Simulation FAILED");
    $fatal(1, "Run stopped after a failure");
  endtask

  // Each vector drains fully before the next one
  task automatic send_singles();
    lanes_t values;
    mask_t  mask;
    for (int n = 0; n < SINGLE_VECTORS; n++) begin
      random_values(argmin_pkg::VALUE_W, values);
      random_mask(mask);
      send_vector(values, mask);
      idle(SINGLE_GAP);
    end
  endtask

  // One vector per cycle, narrow values make ties common
  task automatic stream_vectors(input int cycles, input int width, input bit random_masks);
    lanes_t values;
    mask_t  mask;
    for (int n = 0; n < cycles; n++) begin
      random_values(width, values);
      if (random_masks) begin
        random_mask(mask);
        if (n % 8 == 0) begin
          mask = '0;
        end
      end else begin
        mask = '1;
      end
      send_vector(values, mask);
    end
  endtask

  task automatic send_directed();
    lanes_t values;
    send_vector(equal_lanes(16'h1234), '1);
    send_vector(equal_lanes(16'h1234), 6'b101100);
    send_vector(equal_lanes('0), '0);
    send_vector(equal_lanes(16'hFFFF), 6'b100000);
    // Smallest samples sit in disabled lanes 0 and 3
    values    = equal_lanes(16'd9);
    values[0] = 16'd3;
    values[3] = 16'd1;
    values[4] = 16'd7;
    send_vector(values, 6'b110110);
    send_vector(equal_lanes('0), '1);
  endtask

  // Watchdog
  initial begin
    #((TOTAL_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    stop_with_failure("Watchdog expired before the test sequence finished");
  end

  // First assertion failure in the bound checker ends the run
  initial begin
    wait (argmin_top_i.checker_i.error_count != 0);
    stop_with_failure("An assertion in the checker failed");
  end

  initial begin
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    in_values  = '0;
    in_mask    = '0;
    lfsr_state = LFSR_SEED;

    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    idle(IDLE_CYCLES);
    send_singles();
    stream_vectors(BURST_CYCLES, argmin_pkg::VALUE_W, 1'b0);
    stream_vectors(TIE_CYCLES, 3, 1'b0);
    stream_vectors(MASK_CYCLES, 3, 1'b1);
    send_directed();
    idle(DRAIN_CYCLES);

    if (argmin_top_i.checker_i.error_count == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      stop_with_failure("Checker reported failures by the end of the run");
    end
  end

endmodule

//--- argmin_checker.sv
`timescale 1ns/10ps

module argmin_checker (
  input logic                                           clk,
  input logic                                           rst_n,
  input logic                                           in_valid,
  input argmin_pkg::value_t [argmin_pkg::NUM_LANES-1:0] in_values,
  input logic [argmin_pkg::NUM_LANES-1:0]               in_mask,
  input logic                                           out_valid,
  input argmin_pkg::index_t                             out_index,
  input argmin_pkg::value_t                             out_value,
  input logic                                           out_empty
);

  // Cycles after reset in which out_valid has to stay low
  localparam int QUIET_CYCLES = 16;

  // Expected outcome of one vector
  typedef struct packed {
    logic               empty;
    argmin_pkg::index_t index;
    argmin_pkg::value_t value;
  } result_t;

  // Read by the testbench to stop the run on the first failure
  int error_count = 0;

  logic [argmin_pkg::LATENCY-1:0]                 valid_hist;
  logic [argmin_pkg::NUM_LANES-1:0]               mask_hist   [argmin_pkg::LATENCY];
  argmin_pkg::value_t [argmin_pkg::NUM_LANES-1:0] values_hist [argmin_pkg::LATENCY];
  int                                             run_cycles;
  result_t                                        expected;

  // Linear scan over the lanes in order
  function automatic result_t ref_argmin(
    input argmin_pkg::value_t [argmin_pkg::NUM_LANES-1:0] values,
    input logic [argmin_pkg::NUM_LANES-1:0]               mask
  );
    result_t r;
    r.empty = 1'b1;
    r.index = '0;
    r.value = '0;
    for (int lane = 0; lane < argmin_pkg::NUM_LANES; lane++) begin
      // Strict compare keeps the first lane on equal values
      if (mask[lane] && (r.empty || values[lane] < r.value)) begin
        r.empty = 1'b0;
        r.index = argmin_pkg::index_t'(lane);
        r.value = values[lane];
      end
    end
    return r;
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_hist <= '0;
      run_cycles <= 0;
    end else begin
      valid_hist <= {valid_hist[argmin_pkg::LATENCY-2:0], in_valid};
      if (run_cycles < QUIET_CYCLES) begin
        run_cycles <= run_cycles + 1;
      end
    end
  end

  // Input history, the oldest slot lines up with the outputs
  always_ff @(posedge clk) begin
    mask_hist[0]   <= in_mask;
    values_hist[0] <= in_values;
    for (int i = 1; i < argmin_pkg::LATENCY; i++) begin
      mask_hist[i]   <= mask_hist[i-1];
      values_hist[i] <= values_hist[i-1];
    end
  end

  assign expected = ref_argmin(values_hist[argmin_pkg::LATENCY-1],
                               mask_hist[argmin_pkg::LATENCY-1]);

  a_quiet_in_reset: assert property (@(posedge clk) !rst_n |=> !out_valid)
    else begin
      $error("ERROR a_quiet_in_reset: expected 0, actual %0b", $sampled(out_valid));
      error_count = error_count + 1;
    end

  a_quiet_after_reset: assert property (
    @(posedge clk) rst_n && run_cycles < QUIET_CYCLES |-> !out_valid)
    else begin
      $error("ERROR a_quiet_after_reset: expected 0, actual %0b", $sampled(out_valid));
      error_count = error_count + 1;
    end

  a_valid_latency: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid == valid_hist[argmin_pkg::LATENCY-1])
    else begin
      $error("ERROR a_valid_latency: expected %0b, actual %0b",
             $sampled(valid_hist[argmin_pkg::LATENCY-1]), $sampled(out_valid));
      error_count = error_count + 1;
    end

  a_empty: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid |-> out_empty == expected.empty)
    else begin
      $error("ERROR a_empty: expected %0b, actual %0b",
             $sampled(expected.empty), $sampled(out_empty));
      error_count = error_count + 1;
    end

  a_value: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid && !expected.empty |-> out_value == expected.value)
    else begin
      $error("ERROR a_value: expected %0d, actual %0d",
             $sampled(expected.value), $sampled(out_value));
      error_count = error_count + 1;
    end

  // Ties go to the lowest enabled lane
  a_index: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid && !expected.empty |-> out_index == expected.index)
    else begin
      $error("ERROR a_index: expected %0d, actual %0d",
             $sampled(expected.index), $sampled(out_index));
      error_count = error_count + 1;
    end

  a_disabled_lane: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid && !out_empty |->
      (out_index < argmin_pkg::NUM_LANES) && mask_hist[argmin_pkg::LATENCY-1][out_index])
    else begin
      $error("Winning lane %0d was disabled or does not exist", $sampled(out_index));
      error_count = error_count + 1;
    end

endmodule

bind argmin_top argmin_checker checker_i (
  .clk       (clk),
  .rst_n     (rst_n),
  .in_valid  (in_valid),
  .in_values (in_values),
  .in_mask   (in_mask),
  .out_valid (out_valid),
  .out_index (out_index),
  .out_value (out_value),
  .out_empty (out_empty)
);

//--- argmin_top.sv
`timescale 1ns/10ps

module argmin_top (
  input  logic                                           clk,
  input  logic                                           rst_n,
  input  logic                                           in_valid,
  input  argmin_pkg::value_t [argmin_pkg::NUM_LANES-1:0] in_values,
  input  logic [argmin_pkg::NUM_LANES-1:0]               in_mask,
  output logic                                           out_valid,
  output argmin_pkg::index_t                             out_index,
  output argmin_pkg::value_t                             out_value,
  output logic                                           out_empty
);

  // Entry arrays between stages, index 0 feeds the first level
  argmin_pkg::entry_t level_entries [argmin_pkg::NUM_LEVELS+1][argmin_pkg::NUM_LANES];

  logic load_valid;

  argmin_load load_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_values (in_values),
    .in_mask   (in_mask),
    .entries   (level_entries[0]),
    .valid     (load_valid)
  );

  genvar l;
  generate
    for (l = 0; l < argmin_pkg::NUM_LEVELS; l++) begin : g_level
      argmin_level #(
        .LEVEL (l)
      ) level_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_entries  (level_entries[l]),
        .out_entries (level_entries[l+1])
      );
    end
  endgenerate

  argmin_drain drain_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid     (load_valid),
    .winner    (level_entries[argmin_pkg::NUM_LEVELS][0]),
    .out_valid (out_valid),
    .out_index (out_index),
    .out_value (out_value),
    .out_empty (out_empty)
  );

endmodule

//--- argmin_drain.sv
`timescale 1ns/10ps

module argmin_drain (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               valid,
  input  argmin_pkg::entry_t winner,
  output logic               out_valid,
  output argmin_pkg::index_t out_index,
  output argmin_pkg::value_t out_value,
  output logic               out_empty
);

  // Valid strobe delayed by one cycle per tree level
  logic [argmin_pkg::NUM_LEVELS-1:0] valid_dly;
  logic                              aligned;

  // Lines up with the last level's winner
  assign aligned = valid_dly[argmin_pkg::NUM_LEVELS-1];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_dly <= '0;
      out_valid <= 1'b0;
      out_empty <= 1'b0;
    end else begin
      valid_dly <= {valid_dly[argmin_pkg::NUM_LEVELS-2:0], valid};
      out_valid <= aligned;
      if (aligned) begin
        // No enabled lane reached the root
        out_empty <= !winner.used;
      end
    end
  end

  // Result words update only with a real vector
  always_ff @(posedge clk) begin
    if (aligned) begin
      out_index <= winner.index;
      out_value <= winner.value;
    end
  end

endmodule

//--- argmin_level.sv
`timescale 1ns/10ps

module argmin_level #(
  parameter int LEVEL = 0
) (
  input  logic               clk,
  input  logic               rst_n,
  input  argmin_pkg::entry_t in_entries  [argmin_pkg::NUM_LANES],
  output argmin_pkg::entry_t out_entries [argmin_pkg::NUM_LANES]
);

  // Entry counts going into and out of this level
  localparam int N_IN  = argmin_pkg::level_count(LEVEL);
  localparam int N_OUT = argmin_pkg::level_count(LEVEL + 1);

  genvar k;
  generate
    for (k = 0; k < N_IN; k += 2) begin : g_pair
      if (k + 1 < N_IN) begin : g_node
        // Two inputs reduce to one winner at half the pair position
        argmin_node node_i (
          .clk   (clk),
          .rst_n (rst_n),
          .a     (in_entries[k]),
          .b     (in_entries[k+1]),
          .win   (out_entries[k/2])
        );
      end else begin : g_pass
        // Odd last entry only needs a register to stay in step
        logic               used_q;
        argmin_pkg::index_t index_q;
        argmin_pkg::value_t value_q;

        always_ff @(posedge clk) begin
          if (!rst_n) begin
            used_q <= 1'b0;
          end else begin
            used_q <= in_entries[k].used;
          end
        end

        always_ff @(posedge clk) begin
          index_q <= in_entries[k].index;
          value_q <= in_entries[k].value;
        end

        assign out_entries[k/2] = '{used: used_q, index: index_q, value: value_q};
      end
    end

    // Positions past this level's output are never in use
    for (k = N_OUT; k < argmin_pkg::NUM_LANES; k++) begin : g_unused
      assign out_entries[k] = '0;
    end
  endgenerate

endmodule

//--- argmin_load.sv
`timescale 1ns/10ps

module argmin_load (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  logic                                         in_valid,
  input  argmin_pkg::value_t [argmin_pkg::NUM_LANES-1:0] in_values,
  input  logic [argmin_pkg::NUM_LANES-1:0]             in_mask,
  output argmin_pkg::entry_t                           entries [argmin_pkg::NUM_LANES],
  output logic                                         valid
);

  // Registered in-use bits, one per lane
  logic [argmin_pkg::NUM_LANES-1:0] used_q;

  // Registered samples
  argmin_pkg::value_t value_q [argmin_pkg::NUM_LANES];

  // Control state
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid  <= 1'b0;
      used_q <= '0;
    end else begin
      valid  <= in_valid;
      used_q <= in_mask;
    end
  end

  // Samples are captured every cycle
  // Disabled lanes keep their value but lose the in-use bit
  always_ff @(posedge clk) begin
    for (int i = 0; i < argmin_pkg::NUM_LANES; i++) begin
      value_q[i] <= in_values[i];
    end
  end

  // Tag each lane with its fixed position as the index
  genvar i;
  generate
    for (i = 0; i < argmin_pkg::NUM_LANES; i++) begin : g_lane
      assign entries[i] = '{
        used:  used_q[i],
        index: argmin_pkg::index_t'(i),
        value: value_q[i]
      };
    end
  endgenerate

endmodule

//--- argmin_node.sv
`timescale 1ns/10ps

module argmin_node (
  input  logic               clk,
  input  logic               rst_n,
  input  argmin_pkg::entry_t a,
  input  argmin_pkg::entry_t b,
  output argmin_pkg::entry_t win
);

  logic               a_wins;
  argmin_pkg::entry_t pick;

  logic               used_q;
  argmin_pkg::index_t index_q;
  argmin_pkg::value_t value_q;

  // An unused entry always loses, then value, then lower index on a tie
  always_comb begin
    if (!a.used) begin
      a_wins = 1'b0;
    end else if (!b.used) begin
      a_wins = 1'b1;
    end else if (a.value != b.value) begin
      a_wins = (a.value < b.value);
    end else begin
      a_wins = (a.index < b.index);
    end
    pick = a_wins ? a : b;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      used_q <= 1'b0;
    end else begin
      used_q <= pick.used;
    end
  end

  always_ff @(posedge clk) begin
    index_q <= pick.index;
    value_q <= pick.value;
  end

  assign win = '{used: used_q, index: index_q, value: value_q};

endmodule

//--- argmin_pkg.sv
package argmin_pkg;

  // Sample and lane sizes
  localparam int VALUE_W   = 16;
  localparam int NUM_LANES = 6;
  localparam int INDEX_W   = 3;

  // Tree depth for six lanes goes 6, 3, 2, 1
  localparam int NUM_LEVELS = 3;

  // Load stage, one register per level, then the drain result register
  localparam int LATENCY = NUM_LEVELS + 2;

  typedef logic [VALUE_W-1:0] value_t;
  typedef logic [INDEX_W-1:0] index_t;

  // One candidate moving through the tree
  typedef struct packed {
    logic   used;
    index_t index;
    value_t value;
  } entry_t;

  // Number of entries that enter a given tree level
  function automatic int level_count(input int level);
    int n;
    n = NUM_LANES;
    for (int i = 0; i < level; i++) begin
      // Halve with rounding up, an odd entry passes through
      n = (n + 1) / 2;
    end
    return n;
  endfunction

endpackage
